// File: hw/sdram_ctrl_pkg.sv
// shared geometry, cycle timing, command codes and refresh limits for the sdram controller
package sdram_ctrl_pkg;

  // --------------------------------------------------------------------------
  // geometry, x16 part with four banks
  // --------------------------------------------------------------------------
  typedef logic [1:0]  bank_t;   // bank select
  typedef logic [12:0] row_t;    // row address on A12..A0
  typedef logic [8:0]  col_t;    // word column, A0 of the pair added later
  typedef logic [3:0]  cmd_t;    // {csn, rasn, casn, wen}
  typedef logic [3:0]  credit_t; // outstanding refreshes

  // host address split
  localparam int BANK_LSB = 21;  // bank = addr[22:21]
  localparam int ROW_LSB  = 10;  // row = {addr[24:23], addr[20:10]}
  localparam int COL_LSB  = 2;   // col = addr[10:2]

  // --------------------------------------------------------------------------
  // command encodings
  // --------------------------------------------------------------------------
  localparam cmd_t CMD_NOP   = 4'b0111;
  localparam cmd_t CMD_ACT   = 4'b0011;
  localparam cmd_t CMD_READ  = 4'b0101;
  localparam cmd_t CMD_WRITE = 4'b0100;
  localparam cmd_t CMD_PRE   = 4'b0010; // A10 picks bank or all
  localparam cmd_t CMD_REF   = 4'b0001;
  localparam cmd_t CMD_MRS   = 4'b0000;

  // --------------------------------------------------------------------------
  // timing in clk cycles at 64 MHz, rounded up
  // --------------------------------------------------------------------------
  localparam int T_RP    = 2;   // precharge to act/ref
  localparam int T_RCD   = 2;   // act to read/write
  localparam int T_RFC   = 5;   // ref to anything
  localparam int T_WR    = 1;   // last write beat to next command
  localparam int T_MRD   = 2;   // mode set to anything
  localparam int CAS_LAT = 2;

  localparam int T_REFI    = 500; // average refresh interval
  localparam int INIT_WAIT = 100; // power-up hold with cke low, short for sim

  // mode register: write burst on, cas 2, sequential, burst of 2
  localparam logic [12:0] MODE_WORD = {3'b000, // reserved
                                       1'b0,   // programmed burst on writes
                                       2'b00,  // standard operation
                                       3'b010, // cas latency 2
                                       1'b0,   // sequential
                                       3'b001};

  // refresh credit thresholds
  localparam int REF_CREDITS_MAX  = 8;
  localparam int REF_FORCE_THRESH = 4; // refresh beats the host from here on
  localparam int REF_SOFT_THRESH  = 1; // refresh only while the host is quiet

  localparam int WAIT_W = 8; // shared wait counter, covers INIT_WAIT

endpackage

// File: hw/sdram_refresh_sched.sv
// refresh credit scheduler, turns elapsed refresh intervals into soft and forced requests
module sdram_refresh_sched (
  input  logic clk,
  input  logic resetn,
  input  logic ref_done,  // sequencer issued one REF
  output logic ref_soft,
  output logic ref_force
);
  import sdram_ctrl_pkg::*;

  typedef logic [$clog2(T_REFI)-1:0] refi_t;

  refi_t   refi_cnt; // counts down one interval
  credit_t credits;
  logic    expire;

  assign expire = (refi_cnt == '0);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      refi_cnt <= refi_t'(T_REFI - 1);
      credits  <= '0;
    end else begin
      refi_cnt <= expire ? refi_t'(T_REFI - 1) : refi_cnt - 1'b1; // T_REFI period
      // expiry and ref_done together cancel out
      if (expire && !ref_done && credits != credit_t'(REF_CREDITS_MAX)) begin
        credits <= credits + 1'b1;  // saturates at max
      end else if (ref_done && !expire && credits != '0) begin
        credits <= credits - 1'b1;
      end
    end
  end

  // request levels straight off the credit count
  assign ref_soft  = (credits >= credit_t'(REF_SOFT_THRESH));
  assign ref_force = (credits >= credit_t'(REF_FORCE_THRESH));

  // more than the cap means refreshes got lost on the way
  a_credit_cap : assert property (@(posedge clk) disable iff (!resetn)
    credits <= credit_t'(REF_CREDITS_MAX));

endmodule

// File: hw/sdram_row_tracker.sv
// per-bank open row table, reports hit, bank open and any open for the addressed bank
module sdram_row_tracker (
  input  logic        clk,
  input  logic        resetn,
  input  logic [24:0] addr,
  input  logic        open_set,   // ACT went out for addr
  input  logic        close_bank, // bank PRE for addr
  input  logic        close_all,  // PRE with A10 set
  output logic        row_hit,
  output logic        bank_open,
  output logic        any_open
);
  import sdram_ctrl_pkg::*;

  bank_t      cur_bank;
  row_t       cur_row;
  logic [3:0] open_vld;    // one per bank
  row_t       open_row [4]; // row held open in each bank

  // same split as the sequencer
  assign cur_bank = addr[BANK_LSB +: $bits(bank_t)];
  assign cur_row  = {addr[24:BANK_LSB+2], addr[BANK_LSB-1:ROW_LSB]};

  // --------------------------------------------------------------------------
  // table update, one cycle after the strobe
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      open_vld <= '0;
    end else if (close_all) begin
      open_vld <= '0;
    end else if (open_set) begin
      open_vld[cur_bank] <= 1'b1;
    end else if (close_bank) begin
      open_vld[cur_bank] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (open_set) begin
      open_row[cur_bank] <= cur_row; // only meaningful while valid
    end
  end

  // lookup for the current host address
  assign bank_open = open_vld[cur_bank];
  assign row_hit   = bank_open && (open_row[cur_bank] == cur_row);
  assign any_open  = |open_vld;

  // sequencer opens and closes a bank in separate states
  a_set_close_excl : assert property (@(posedge clk) disable iff (!resetn)
    !(open_set && close_bank));

endmodule

// File: hw/sdram_cmd_seq.sv
// sdram command sequencer, runs init, refresh, precharge, activate and the two-beat accesses
module sdram_cmd_seq (
  input  logic                  clk,
  input  logic                  resetn,
  // host side
  input  logic [24:0]           addr,
  input  logic [31:0]           din,
  input  logic [3:0]            wmask,  // 0 means read
  input  logic                  valid,
  output logic [31:0]           dout,
  output logic                  ready,  // one-cycle pulse
  // refresh scheduler
  input  logic                  ref_soft,
  input  logic                  ref_force,
  output logic                  ref_done,
  // row tracker
  input  logic                  row_hit,
  input  logic                  bank_open,
  input  logic                  any_open,
  output logic                  open_set,
  output logic                  close_bank,
  output logic                  close_all,
  // sdram pins, all registered
  output logic                  cke,
  output logic                  csn,
  output logic                  rasn,
  output logic                  casn,
  output logic                  wen,
  output sdram_ctrl_pkg::bank_t ba,
  output logic [12:0]           saddr,
  output logic [1:0]            dqm,
  output logic [15:0]           dq_out,
  output logic                  dq_oe,
  input  logic [15:0]           dq_in
);
  import sdram_ctrl_pkg::*;

  typedef enum logic [3:0] {
    INIT_RESET, INIT_CKE, INIT_PRE, INIT_REF0, INIT_REF1, INIT_MRS,
    IDLE, ACTIVATE, READ_CMD, READ_L, READ_H, WRITE_L, WRITE_H, REFRESH, WAIT
  } state_t;

  state_t              state;
  state_t              ret_state; // where WAIT goes next
  logic [WAIT_W-1:0]   wait_cnt;
  logic                pend_rdy;  // pulse ready when WAIT ends
  cmd_t                cmd;

  bank_t cur_bank;
  row_t  cur_row;
  col_t  cur_col;
  logic  is_read;

  assign cur_bank = addr[BANK_LSB +: $bits(bank_t)];
  assign cur_row  = {addr[24:BANK_LSB+2], addr[BANK_LSB-1:ROW_LSB]};
  assign cur_col  = addr[COL_LSB +: $bits(col_t)];
  assign is_read  = (wmask == 4'b0000);

  assign {csn, rasn, casn, wen} = cmd;

  // --------------------------------------------------------------------------
  // FSM, a wait of n keeps the next command n+1 cycles behind this one
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state      <= INIT_RESET;
      ret_state  <= INIT_RESET;
      wait_cnt   <= '0;
      pend_rdy   <= 1'b0;
      ready      <= 1'b0;
      ref_done   <= 1'b0;
      open_set   <= 1'b0;
      close_bank <= 1'b0;
      close_all  <= 1'b0;
      cke        <= 1'b0;
      cmd        <= CMD_NOP;
      dqm        <= 2'b11;
      dq_oe      <= 1'b0;
    end else begin
      // pulses and pin defaults
      cmd        <= CMD_NOP;
      ready      <= 1'b0;
      ref_done   <= 1'b0;
      open_set   <= 1'b0;
      close_bank <= 1'b0;
      close_all  <= 1'b0;
      dq_oe      <= 1'b0;

      unique case (state)
        // power-up hold, cke low
        INIT_RESET: begin
          cke       <= 1'b0;
          wait_cnt  <= WAIT_W'(INIT_WAIT - 1);
          ret_state <= INIT_CKE;
          state     <= WAIT;
        end
        INIT_CKE: begin
          cke       <= 1'b1;
          wait_cnt  <= WAIT_W'(1); // a couple of NOPs with clock enabled
          ret_state <= INIT_PRE;
          state     <= WAIT;
        end
        INIT_PRE: begin
          cmd       <= CMD_PRE;
          saddr     <= 13'h0400;   // A10 set, all banks
          close_all <= 1'b1;
          wait_cnt  <= WAIT_W'(T_RP - 1);
          ret_state <= INIT_REF0;
          state     <= WAIT;
        end
        INIT_REF0: begin
          cmd       <= CMD_REF;    // no credit taken during init
          wait_cnt  <= WAIT_W'(T_RFC - 1);
          ret_state <= INIT_REF1;
          state     <= WAIT;
        end
        INIT_REF1: begin
          cmd       <= CMD_REF;
          wait_cnt  <= WAIT_W'(T_RFC - 1);
          ret_state <= INIT_MRS;
          state     <= WAIT;
        end
        INIT_MRS: begin
          cmd       <= CMD_MRS;
          ba        <= '0;
          saddr     <= MODE_WORD;
          wait_cnt  <= WAIT_W'(T_MRD - 1);
          ret_state <= IDLE;
          state     <= WAIT;
        end

        // arbitration, forced refresh first, soft one only with no host request
        IDLE: begin
          dqm <= 2'b11;
          if (ref_force || (ref_soft && !valid)) begin
            if (any_open) begin
              cmd       <= CMD_PRE;
              saddr     <= 13'h0400; // precharge all before REF
              close_all <= 1'b1;
              wait_cnt  <= WAIT_W'(T_RP - 1);
              ret_state <= REFRESH;
              state     <= WAIT;
            end else begin
              state <= REFRESH;
            end
          end else if (valid && !ready) begin // ready cycle still shows old request
            if (row_hit) begin
              state <= is_read ? READ_CMD : WRITE_L;  // row already open
            end else if (bank_open) begin
              cmd        <= CMD_PRE;  // other row open here, close it
              ba         <= cur_bank;
              saddr      <= 13'h0000; // A10 low, this bank only
              close_bank <= 1'b1;
              wait_cnt   <= WAIT_W'(T_RP - 1);
              ret_state  <= ACTIVATE;
              state      <= WAIT;
            end else begin
              state <= ACTIVATE;
            end
          end
        end

        ACTIVATE: begin
          cmd       <= CMD_ACT;
          ba        <= cur_bank;
          saddr     <= cur_row;
          open_set  <= 1'b1;
          wait_cnt  <= WAIT_W'(T_RCD - 1);
          ret_state <= is_read ? READ_CMD : WRITE_L;
          state     <= WAIT;
        end

        // read, low word CAS_LAT edges after READ, high word one later
        READ_CMD: begin
          cmd       <= CMD_READ;
          ba        <= cur_bank;
          saddr     <= {3'b000, cur_col, 1'b0}; // A10 low keeps the row open
          dqm       <= 2'b00;
          wait_cnt  <= WAIT_W'(CAS_LAT - 1);
          ret_state <= READ_L;
          state     <= WAIT;
        end
        READ_L: begin
          dout[15:0] <= dq_in;
          state      <= READ_H;
        end
        READ_H: begin
          dout[31:16] <= dq_in;
          ready       <= 1'b1;  // lands with the high word
          state       <= IDLE;
        end

        // write, low word with WRITE and high word on the NOP after it
        WRITE_L: begin
          cmd    <= CMD_WRITE;
          ba     <= cur_bank;
          saddr  <= {3'b000, cur_col, 1'b0};
          dqm    <= ~wmask[1:0]; // dqm high masks a byte
          dq_out <= din[15:0];
          dq_oe  <= 1'b1;
          state  <= WRITE_H;
        end
        WRITE_H: begin
          dqm       <= ~wmask[3:2];
          dq_out    <= din[31:16];
          dq_oe     <= 1'b1;
          wait_cnt  <= WAIT_W'(T_WR); // write recovery
          pend_rdy  <= 1'b1;
          ret_state <= IDLE;
          state     <= WAIT;
        end

        REFRESH: begin
          cmd       <= CMD_REF;
          ref_done  <= 1'b1;  // scheduler drops a credit
          wait_cnt  <= WAIT_W'(T_RFC - 1);
          ret_state <= IDLE;
          state     <= WAIT;
        end

        // shared delay, NOPs on the pins
        WAIT: begin
          wait_cnt <= wait_cnt - 1'b1;
          if (wait_cnt == WAIT_W'(1)) begin
            state    <= ret_state;
            ready    <= pend_rdy;
            pend_rdy <= 1'b0;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  // data pins driven only with WRITE or the beat right after it
  a_oe_write_only : assert property (@(posedge clk) disable iff (!resetn)
    dq_oe |-> (cmd == CMD_WRITE) || ($past(cmd) == CMD_WRITE));

  // ACT and REF only leave once the previous wait has run out
  a_act_ref_waited : assert property (@(posedge clk) disable iff (!resetn)
    (cmd == CMD_ACT || cmd == CMD_REF) |-> $past(wait_cnt) == '0);

endmodule

// File: hw/sdram_ctrl.sv
// sdram controller top, connects scheduler, row tracker and sequencer to host and pins
module sdram_ctrl (
  input  logic                  clk,
  input  logic                  resetn,
  // host side
  input  logic [24:0]           addr,
  input  logic [31:0]           din,
  input  logic [3:0]            wmask,
  input  logic                  valid,
  output logic [31:0]           dout,
  output logic                  ready,
  // sdram pins, a board top adds the dq tristate
  output logic                  cke,
  output logic                  csn,
  output logic                  rasn,
  output logic                  casn,
  output logic                  wen,
  output sdram_ctrl_pkg::bank_t ba,
  output logic [12:0]           saddr,
  output logic [1:0]            dqm,
  output logic [15:0]           dq_out,
  output logic                  dq_oe,
  input  logic [15:0]           dq_in
);

  // scheduler <-> sequencer
  logic ref_soft;
  logic ref_force;
  logic ref_done;

  // tracker <-> sequencer
  logic row_hit;
  logic bank_open;
  logic any_open;
  logic open_set;
  logic close_bank;
  logic close_all;

  sdram_refresh_sched sdram_refresh_sched_i (
    .clk       (clk),
    .resetn    (resetn),
    .ref_done  (ref_done),
    .ref_soft  (ref_soft),
    .ref_force (ref_force)
  );

  sdram_row_tracker sdram_row_tracker_i (
    .clk        (clk),
    .resetn     (resetn),
    .addr       (addr),
    .open_set   (open_set),
    .close_bank (close_bank),
    .close_all  (close_all),
    .row_hit    (row_hit),
    .bank_open  (bank_open),
    .any_open   (any_open)
  );

  sdram_cmd_seq sdram_cmd_seq_i (
    .clk        (clk),
    .resetn     (resetn),
    .addr       (addr),
    .din        (din),
    .wmask      (wmask),
    .valid      (valid),
    .dout       (dout),
    .ready      (ready),
    .ref_soft   (ref_soft),
    .ref_force  (ref_force),
    .ref_done   (ref_done),
    .row_hit    (row_hit),
    .bank_open  (bank_open),
    .any_open   (any_open),
    .open_set   (open_set),
    .close_bank (close_bank),
    .close_all  (close_all),
    .cke        (cke),
    .csn        (csn),
    .rasn       (rasn),
    .casn       (casn),
    .wen        (wen),
    .ba         (ba),
    .saddr      (saddr),
    .dqm        (dqm),
    .dq_out     (dq_out),
    .dq_oe      (dq_oe),
    .dq_in      (dq_in)
  );

endmodule

// File: verif/sdram_model.sv
// behavioural x16 sdram that stores masked writes and returns read beats after the cas latency
module sdram_model (
  input  logic        clk,
  input  logic        cke,
  input  logic        csn,
  input  logic        rasn,
  input  logic        casn,
  input  logic        wen,
  input  logic [1:0]  ba,
  input  logic [12:0] saddr,
  input  logic [1:0]  dqm,
  input  logic [15:0] dq_out,
  input  logic        dq_oe,
  output logic [15:0] dq_in
);
  import sdram_ctrl_pkg::*;

  cmd_t        cmd;
  row_t        act_row [4];           // row latched by ACT in each bank
  logic [15:0] mem [logic [24:0]];    // sparse store keyed by {bank, row, col with A0}
  logic        rd_v [CAS_LAT];        // read pipe where stage 0 is this edge
  logic [24:0] rd_a [CAS_LAT];
  logic        wr_h;                  // high write beat due on this edge
  logic [24:0] wr_a;

  assign cmd = {csn, rasn, casn, wen};

  // dqm high keeps the old byte
  function automatic logic [15:0] merge_beat(input logic [15:0] old, input logic [15:0] data,
                                             input logic [1:0] mask_n);
    logic [15:0] res;
    res = old;
    if (!mask_n[0]) res[7:0]  = data[7:0];
    if (!mask_n[1]) res[15:8] = data[15:8];
    return res;
  endfunction

  function automatic logic [15:0] fetch(input logic [24:0] k);
    return mem.exists(k) ? mem[k] : 16'h0000; // never written reads as zero
  endfunction

  initial begin
    wr_h  = 1'b0;
    dq_in = 16'h0000;
    for (int i = 0; i < CAS_LAT; i++) begin
      rd_v[i] = 1'b0;
      rd_a[i] = '0;
    end
  end

  always @(posedge clk) begin
    // shift the read pipe so the newest read sits at stage 0
    for (int i = CAS_LAT - 1; i > 0; i--) begin
      rd_v[i] = rd_v[i-1];
      rd_a[i] = rd_a[i-1];
    end
    rd_v[0] = cke && (cmd == CMD_READ);
    rd_a[0] = {ba, act_row[ba], saddr[9:0]};

    if (wr_h && dq_oe) begin
      mem[wr_a] = merge_beat(fetch(wr_a), dq_out, dqm); // second beat with A0 set
    end
    wr_h = 1'b0;

    if (cke) begin
      case (cmd)
        CMD_ACT:   act_row[ba] = saddr;
        CMD_WRITE: begin
          if (dq_oe) begin // first beat lands only while dq is driven
            mem[{ba, act_row[ba], saddr[9:0]}] =
              merge_beat(fetch({ba, act_row[ba], saddr[9:0]}), dq_out, dqm);
          end
          wr_a = {ba, act_row[ba], saddr[9:1], 1'b1};
          wr_h = 1'b1;
        end
        default: ;
      endcase
    end

    // low beat lands CAS_LAT-1 cycles after READ is seen and the high beat one later
    if (rd_v[CAS_LAT-2]) begin
      dq_in <= fetch(rd_a[CAS_LAT-2]);
    end else if (rd_v[CAS_LAT-1]) begin
      dq_in <= fetch({rd_a[CAS_LAT-1][24:1], 1'b1});
    end else begin
      dq_in <= 16'h0000;
    end
  end

endmodule

// File: verif/sdram_checker.sv
// pin and host monitor, checks init order, row policy, refresh, command spacing and read data
module sdram_checker (
  input  logic        clk,
  input  logic        resetn,
  input  logic        valid,
  input  logic        ready,
  input  logic [24:0] addr,
  input  logic [3:0]  wmask,
  input  logic [31:0] dout,
  input  logic [31:0] exp_dout,  // reference word for the access held by the host
  input  logic        cke,
  input  logic        csn,
  input  logic        rasn,
  input  logic        casn,
  input  logic        wen,
  input  logic [1:0]  ba,
  input  logic [12:0] saddr,
  output int          err_count
);
  import sdram_ctrl_pkg::*;

  cmd_t       cmd;
  bank_t      h_bank;
  row_t       h_row;
  int         cyc;
  int         cke_low;
  int         init_step;   // 4 once MRS is seen
  int         post_cyc;
  int         ref_cnt;
  int         last_act;
  int         last_pre;
  int         last_ref;
  int         last_mrs;
  int         last_wrh;    // cycle of the high write beat
  logic       rate_flagged;
  logic [3:0] open_v;
  row_t       open_r [4];

  assign cmd    = {csn, rasn, casn, wen};
  assign h_bank = addr[BANK_LSB +: 2];
  assign h_row  = {addr[24:BANK_LSB+2], addr[BANK_LSB-1:ROW_LSB]};

  initial err_count = 0;

  task automatic fail_value(input string sig, input int expv, input int got);
    err_count++;
    $display("[FAIL] %0t %s expected %0d got %0d", $time, sig, expv, got);
  endtask

  task automatic min_gap(input string what, input int since, input int need);
    if (cyc - since < need) begin
      err_count++;
      $display("[FAIL] %0t gap_after_%s expected >= %0d got %0d", $time, what, need,
               cyc - since);
    end
  endtask

  task automatic problem(input string msg);
    err_count++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // --------------------------------------------------------------------------
  // init phase, expected order PRE all, REF, REF, MRS
  // --------------------------------------------------------------------------
  task automatic check_init();
    case (init_step)
      0: begin
        if (cke_low < INIT_WAIT) fail_value("cke_low_cycles", INIT_WAIT, cke_low);
        if (cmd != CMD_PRE || !saddr[10]) fail_value("init_pre_cmd", CMD_PRE, cmd);
      end
      1, 2: if (cmd != CMD_REF) fail_value("init_ref_cmd", CMD_REF, cmd);
      default: begin
        if (cmd != CMD_MRS) fail_value("init_mrs_cmd", CMD_MRS, cmd);
        else if (saddr != MODE_WORD) fail_value("mode_word", MODE_WORD, saddr);
      end
    endcase
    init_step++;
  endtask

  // row policy tracked from the pins
  task automatic check_rows();
    case (cmd)
      CMD_ACT: begin
        if (open_v[ba]) problem("ACT to a bank that still has a row open");
        open_v[ba] = 1'b1;
        open_r[ba] = saddr;
      end
      CMD_PRE: begin
        if (saddr[10]) begin
          open_v = '0;
        end else begin
          if (valid && h_bank == ba && open_v[ba] && open_r[ba] == h_row)
            problem("bank precharge although the host row was already open");
          open_v[ba] = 1'b0;
        end
      end
      CMD_READ, CMD_WRITE: begin
        if (!open_v[ba]) problem("READ or WRITE to a bank with no open row");
        else if (open_r[ba] != h_row) fail_value("open_row", h_row, open_r[ba]);
      end
      CMD_REF: begin
        if (|open_v) problem("REF issued while a bank is open");
        ref_cnt++;
      end
      default: problem("unexpected command after init");
    endcase
  endtask

  always @(posedge clk) begin
    if (!resetn) begin
      cyc          = 0;
      cke_low      = 0;
      init_step    = 0;
      post_cyc     = 0;
      ref_cnt      = 0;
      last_act     = -1000;
      last_pre     = -1000;
      last_ref     = -1000;
      last_mrs     = -1000;
      last_wrh     = -1000;
      rate_flagged = 1'b0;
      open_v       = '0;
    end else begin
      cyc++;
      if (!cke) cke_low++;
      if (init_step == 4) post_cyc++;
      if (init_step < 4 && ready) problem("ready pulsed during init");

      if (cmd != CMD_NOP) begin
        if (!cke) problem("command issued with cke low");
        if (cmd == CMD_ACT || cmd == CMD_REF) min_gap("pre", last_pre, T_RP);
        if (cmd == CMD_READ || cmd == CMD_WRITE) min_gap("act", last_act, T_RCD);
        min_gap("ref", last_ref, T_RFC);
        min_gap("mrs", last_mrs, T_MRD);
        min_gap("write", last_wrh, T_WR);
        if (init_step < 4) check_init();
        else check_rows();
        case (cmd)
          CMD_ACT:   last_act = cyc;
          CMD_PRE:   last_pre = cyc;
          CMD_REF:   last_ref = cyc;
          CMD_MRS:   last_mrs = cyc;
          CMD_WRITE: last_wrh = cyc + 1; // high beat follows on the NOP
          default: ;
        endcase
      end

      // read data at the ready pulse
      if (ready && valid && wmask == 4'b0000 && dout !== exp_dout) begin
        err_count++;
        $display("[FAIL] %0t dout expected %h got %h", $time, exp_dout, dout);
      end

      // refreshes must keep up with the interval, less the credit store
      if (!rate_flagged && post_cyc / T_REFI > ref_cnt + REF_CREDITS_MAX) begin
        rate_flagged = 1'b1;
        problem("refresh count fell behind the refresh interval");
      end
    end
  end

endmodule

// File: verif/tb_sdram_ctrl.sv
// testbench top that drives random host accesses into the sdram controller and reports the result
module tb_sdram_ctrl;
  import sdram_ctrl_pkg::*;

  localparam int          N_ACC     = 300;
  localparam logic [31:0] SEED      = 32'h74302e4e;
  localparam int          WORST_ACC = 40; // gap, refresh, precharge, activate and access
  localparam int          TAIL_CYC  = (REF_CREDITS_MAX + 4) * T_REFI; // idle past the credit store
  localparam int          CYC_LIMIT = INIT_WAIT + 50 + N_ACC * WORST_ACC + TAIL_CYC;

  logic        clk;
  logic        resetn;
  logic [24:0] addr;
  logic [31:0] din;
  logic [3:0]  wmask;
  logic        valid;
  logic [31:0] dout;
  logic        ready;
  logic        cke, csn, rasn, casn, wen;
  bank_t       ba;
  logic [12:0] saddr;
  logic [1:0]  dqm;
  logic [15:0] dq_out;
  logic        dq_oe;
  logic [15:0] dq_in;
  logic [31:0] exp_dout;
  int          err_count;
  int          cyc;
  logic [31:0] lfsr;
  logic [31:0] ref_mem [logic [22:0]]; // reference, keyed by addr[24:2]
  row_t        row_set [4];            // few rows so hits and misses both occur

  sdram_ctrl sdram_ctrl_i (
    .clk(clk), .resetn(resetn), .addr(addr), .din(din), .wmask(wmask), .valid(valid),
    .dout(dout), .ready(ready), .cke(cke), .csn(csn), .rasn(rasn), .casn(casn),
    .wen(wen), .ba(ba), .saddr(saddr), .dqm(dqm), .dq_out(dq_out), .dq_oe(dq_oe),
    .dq_in(dq_in)
  );

  sdram_model sdram_model_i (
    .clk(clk), .cke(cke), .csn(csn), .rasn(rasn), .casn(casn), .wen(wen), .ba(ba),
    .saddr(saddr), .dqm(dqm), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
  );

  sdram_checker sdram_checker_i (
    .clk(clk), .resetn(resetn), .valid(valid), .ready(ready), .addr(addr),
    .wmask(wmask), .dout(dout), .exp_dout(exp_dout), .cke(cke), .csn(csn),
    .rasn(rasn), .casn(casn), .wen(wen), .ba(ba), .saddr(saddr), .err_count(err_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // galois lfsr stepped once per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);
    end
  endtask

  // byte merge under the host mask
  function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] mask);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // one access from the idle gap to the ready pulse
  task automatic do_access();
    logic [31:0] r_gap, r_wr, r_bank, r_row, r_col, r_data, r_mask;
    logic [31:0] old;
    logic [24:0] a;
    logic [3:0]  m;
    row_t        r;
    take_bits(3, r_gap);
    repeat (r_gap) begin
      @(posedge clk);
      #10;
    end
    take_bits(1, r_wr);
    take_bits(2, r_bank);
    take_bits(2, r_row);
    take_bits(3, r_col);
    take_bits(32, r_data);
    take_bits(4, r_mask);
    r        = row_set[r_row[1:0]];
    a        = '0;
    a[24:23] = r[12:11];
    a[22:21] = r_bank[1:0];
    a[20:10] = r[10:0];
    a[4:2]   = r_col[2:0];
    old      = ref_mem.exists(a[24:2]) ? ref_mem[a[24:2]] : 32'h0;
    if (r_wr[0]) begin
      m               = (r_mask[3:0] == 4'h0) ? 4'hf : r_mask[3:0]; // zero would be a read
      ref_mem[a[24:2]] = merge_word(old, r_data, m);
      exp_dout        = 32'h0;
    end else begin
      m        = 4'h0;
      exp_dout = old;
    end
    addr  = a;
    din   = r_data;
    wmask = m;
    valid = 1'b1;
    @(negedge clk);
    while (!ready) @(negedge clk);
    @(posedge clk);
    #10;
    valid = 1'b0;
    wmask = 4'h0;
  endtask

  // watchdog ends a stuck run
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("timeout: no finish within %0d cycles", CYC_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    cyc        = 0;
    lfsr       = SEED;
    row_set[0] = 13'h0000;
    row_set[1] = 13'h0001;
    row_set[2] = 13'h1555;
    row_set[3] = 13'h0aaa;
    resetn     = 1'b0;
    addr       = '0;
    din        = '0;
    wmask      = 4'h0;
    valid      = 1'b0;
    exp_dout   = '0;
    repeat (8) @(posedge clk);
    #10;
    resetn = 1'b1;
    for (int n = 0; n < N_ACC; n++) do_access();
    // quiet host, refresh alone has to keep pace with the interval
    repeat (TAIL_CYC) @(posedge clk);
    $display("done: %0d accesses, %0d cycles, %0d errors", N_ACC, cyc, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: sim.f
hw/sdram_ctrl_pkg.sv
hw/sdram_refresh_sched.sv
hw/sdram_row_tracker.sv
hw/sdram_cmd_seq.sv
hw/sdram_ctrl.sv
verif/sdram_model.sv
verif/sdram_checker.sv
verif/tb_sdram_ctrl.sv

// File: Makefile
# Verilator build and run of the sdram controller testbench

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module tb_sdram_ctrl -f sim.f -o vsim
	out="$$(./obj_dir/vsim)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
